// ==== hw/ccl_frame_pkg.sv ====
package ccl_frame_pkg;

    localparam int FRAME_WIDTH  = 40;
    localparam int FRAME_HEIGHT = 30;
    localparam int NUM_LABELS   = 16;   // label 0 is background

    typedef logic [5:0] coord_x_t;      // column 0..39
    typedef logic [4:0] coord_y_t;      // row 0..29
    typedef logic [3:0] label_t;

    // coordinate of the final pixel in raster order
    localparam coord_x_t LAST_X = coord_x_t'(FRAME_WIDTH - 1);
    localparam coord_y_t LAST_Y = coord_y_t'(FRAME_HEIGHT - 1);

    // one streamed pixel, 16 bits
    typedef struct packed {
        coord_x_t x;
        coord_y_t y;
        label_t   label;
        logic     mask;
    } pixel_t;

endpackage

// ==== hw/blob_pkg.sv ====
package blob_pkg;
    import ccl_frame_pkg::*;

    localparam int AREA_W = 11;         // up to 1200 pixels per label
    localparam int SUM_W  = 16;         // worst case 1200 * 39 still fits

    typedef logic [AREA_W-1:0] area_t;
    typedef logic [SUM_W-1:0]  sum_t;

    // running statistics of one label, 43 bits
    typedef struct packed {
        area_t area;
        sum_t  x_sum;
        sum_t  y_sum;
    } label_stats_t;

    localparam area_t MIN_AREA   = area_t'(50);   // smaller labels are pruned
    localparam int    DIV_CYCLES = SUM_W;         // one quotient bit per cycle
    localparam int    DIV_CNT_W  = $clog2(DIV_CYCLES);

    // retained blob with its centre of mass, 26 bits
    typedef struct packed {
        label_t   label;
        area_t    area;
        coord_x_t com_x;
        coord_y_t com_y;
    } blob_t;

    localparam int TOP_N = 3;
    typedef blob_t [TOP_N-1:0] blob_list_t;       // entry 0 is the largest

endpackage

// ==== hw/label_accumulator.sv ====
`timescale 1ns/100ps

module label_accumulator import ccl_frame_pkg::*, blob_pkg::*; (
    input  logic         clk_in,
    input  logic         rst_in,
    input  pixel_t       pix_in,
    input  logic         valid_in,
    input  logic         clear,
    input  logic         capture,
    input  label_t       rd_label,
    output label_stats_t rd_stats,
    output logic         frame_done
);

    label_stats_t stats [NUM_LABELS];
    logic         take;         // pixel counts toward its label
    logic         last_pix;

    assign take = capture && valid_in && pix_in.mask && (pix_in.label != '0);

    // the last coordinate ends capture whatever its mask
    assign last_pix = capture && valid_in && (pix_in.x == LAST_X) && (pix_in.y == LAST_Y);

    always_ff @(posedge clk_in) begin
        if (clear) begin
            for (int i = 0; i < NUM_LABELS; i++) begin
                stats[i] <= '0;
            end
        end else if (take) begin
            stats[pix_in.label].area  <= stats[pix_in.label].area + 1'b1;
            stats[pix_in.label].x_sum <= stats[pix_in.label].x_sum + sum_t'(pix_in.x);
            stats[pix_in.label].y_sum <= stats[pix_in.label].y_sum + sum_t'(pix_in.y);
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            frame_done <= 1'b0;
        end else begin
            frame_done <= last_pix;     // one cycle after the final pixel is summed
        end
    end

    assign rd_stats = stats[rd_label];   // combinational read for the scanner

endmodule

// ==== hw/serial_divider.sv ====
`timescale 1ns/100ps

module serial_divider import blob_pkg::*; #(
    parameter type quot_t = logic [SUM_W-1:0]
) (
    input  logic  clk_in,
    input  logic  rst_in,
    input  logic  start,
    input  sum_t  dividend,
    input  area_t divisor,
    output quot_t quotient,
    output logic  done
);

    sum_t                 quo_q;    // dividend bits leave at the top, quotient bits enter below
    area_t                rem_q;
    area_t                div_q;
    logic                 running;
    logic [DIV_CNT_W-1:0] count;

    sum_t            num_src;
    area_t           rem_src;
    area_t           div_src;
    logic [AREA_W:0] trial;
    logic [AREA_W:0] diff;
    logic            fits;

    // the first step works straight from the inputs so done lands DIV_CYCLES after start
    assign num_src = start ? dividend : quo_q;
    assign rem_src = start ? area_t'(0) : rem_q;
    assign div_src = start ? divisor : div_q;

    assign trial = {rem_src, num_src[SUM_W-1]};
    assign diff  = trial - {1'b0, div_src};
    assign fits  = (trial >= {1'b0, div_src});

    always_ff @(posedge clk_in) begin
        if (start || running) begin
            quo_q <= {num_src[SUM_W-2:0], fits};
            rem_q <= fits ? diff[AREA_W-1:0] : trial[AREA_W-1:0];   // restore when it does not fit
            div_q <= div_src;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            running <= 1'b0;
            count   <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                running <= 1'b1;
                count   <= '0;
            end else if (running) begin
                count <= count + 1'b1;
                if (count == DIV_CNT_W'(DIV_CYCLES - 2)) begin   // final quotient bit
                    running <= 1'b0;
                    done    <= 1'b1;
                end
            end
        end
    end

    // a centre of mass always lies inside the frame, so the upper bits are zero
    assign quotient = quot_t'(quo_q);

endmodule

// ==== hw/prune_scanner.sv ====
`timescale 1ns/100ps

module prune_scanner import ccl_frame_pkg::*, blob_pkg::*; (
    input  logic         clk_in,
    input  logic         rst_in,
    input  logic         new_frame_in,
    input  logic         frame_done,
    input  label_stats_t rd_stats,
    output logic         clear,
    output logic         capture,
    output label_t       rd_label,
    output logic         busy_out,
    output logic         valid_out,
    output label_t       num_blobs,
    output logic         insert,
    output logic         reset_list,
    output blob_t        new_blob
);

    typedef enum logic [2:0] {st_idle, st_capture, st_scan, st_divide, st_done} state_t;

    state_t   state;
    label_t   lbl;          // label under inspection
    logic     accept;
    logic     keep;         // label survives pruning
    logic     last_lbl;
    logic     div_start;
    logic     x_done;
    logic     y_done;
    logic     x_got;
    logic     y_got;
    coord_x_t x_quot;
    coord_y_t y_quot;
    blob_t    blob_q;

    assign accept     = ((state == st_idle) || (state == st_done)) && new_frame_in;
    assign clear      = accept;
    assign capture    = (state == st_capture);
    assign reset_list = capture && frame_done;   // list restarts with the scan
    assign rd_label   = lbl;
    assign keep       = (rd_stats.area >= MIN_AREA);
    assign last_lbl   = (lbl == label_t'(NUM_LABELS - 1));
    assign div_start  = (state == st_scan) && keep;
    assign insert     = (state == st_divide) && x_got && y_got;
    assign new_blob   = blob_q;

    serial_divider #(.quot_t(coord_x_t)) div_x (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .start    (div_start),
        .dividend (rd_stats.x_sum),
        .divisor  (rd_stats.area),
        .quotient (x_quot),
        .done     (x_done)
    );

    serial_divider #(.quot_t(coord_y_t)) div_y (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .start    (div_start),
        .dividend (rd_stats.y_sum),
        .divisor  (rd_stats.area),
        .quotient (y_quot),
        .done     (y_done)
    );

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state     <= st_idle;
            lbl       <= label_t'(1);
            busy_out  <= 1'b0;
            valid_out <= 1'b0;
            num_blobs <= '0;
            x_got     <= 1'b0;
            y_got     <= 1'b0;
        end else begin
            valid_out <= 1'b0;
            case (state)
                st_idle, st_done: begin
                    if (accept) begin
                        state    <= st_capture;
                        busy_out <= 1'b1;
                    end else begin
                        state <= st_idle;
                    end
                end
                st_capture: begin
                    if (frame_done) begin
                        state     <= st_scan;
                        lbl       <= label_t'(1);   // skip background
                        num_blobs <= '0;
                    end
                end
                st_scan: begin
                    if (keep) begin
                        state <= st_divide;
                        x_got <= 1'b0;
                        y_got <= 1'b0;
                    end else if (last_lbl) begin
                        state     <= st_done;
                        busy_out  <= 1'b0;
                        valid_out <= 1'b1;
                    end else begin
                        lbl <= lbl + 1'b1;          // empty or pruned, one cycle
                    end
                end
                st_divide: begin
                    if (x_done) begin
                        x_got <= 1'b1;
                    end
                    if (y_done) begin
                        y_got <= 1'b1;
                    end
                    if (insert) begin
                        num_blobs <= num_blobs + 1'b1;
                        if (last_lbl) begin
                            state     <= st_done;
                            busy_out  <= 1'b0;
                            valid_out <= 1'b1;
                        end else begin
                            state <= st_scan;
                            lbl   <= lbl + 1'b1;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // blob record, filled at launch and completed as each quotient arrives
    always_ff @(posedge clk_in) begin
        if (div_start) begin
            blob_q.label <= lbl;
            blob_q.area  <= rd_stats.area;
        end
        if (x_done) begin
            blob_q.com_x <= x_quot;
        end
        if (y_done) begin
            blob_q.com_y <= y_quot;
        end
    end

endmodule

// ==== hw/top_three_tracker.sv ====
`timescale 1ns/100ps

module top_three_tracker import blob_pkg::*; (
    input  logic       clk_in,
    input  logic       rst_in,
    input  logic       reset_list,
    input  logic       insert,
    input  blob_t      new_blob,
    output blob_list_t top_blobs
);

    blob_list_t       list_q;
    blob_list_t       list_d;
    logic [TOP_N-1:0] beats;    // new blob goes ahead of entry i

    always_comb begin
        for (int i = 0; i < TOP_N; i++) begin
            // strict compare keeps earlier labels ahead on a tie
            beats[i] = (new_blob.area > list_q[i].area);
        end
        list_d[0] = beats[0] ? new_blob : list_q[0];
        for (int i = 1; i < TOP_N; i++) begin
            if (beats[i-1]) begin
                list_d[i] = list_q[i-1];      // shifted down, last one drops off
            end else if (beats[i]) begin
                list_d[i] = new_blob;
            end else begin
                list_d[i] = list_q[i];
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in || reset_list) begin
            list_q <= '0;
        end else if (insert) begin
            list_q <= list_d;
        end
    end

    assign top_blobs = list_q;

endmodule

// ==== hw/blob_stats_top.sv ====
`timescale 1ns/100ps

module blob_stats_top import ccl_frame_pkg::*, blob_pkg::*; (
    input  logic       clk_in,
    input  logic       rst_in,
    input  coord_x_t   x_in,
    input  coord_y_t   y_in,
    input  label_t     label_in,
    input  logic       mask_in,
    input  logic       valid_in,
    input  logic       new_frame_in,
    output logic       valid_out,
    output logic       busy_out,
    output label_t     num_blobs,
    output blob_list_t top_blobs
);

    pixel_t       pix;
    logic         clear;
    logic         capture;
    logic         frame_done;
    logic         insert;
    logic         reset_list;
    label_t       rd_label;
    label_stats_t rd_stats;
    blob_t        new_blob;

    assign pix = '{x: x_in, y: y_in, label: label_in, mask: mask_in};

    label_accumulator u_accum (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .pix_in     (pix),
        .valid_in   (valid_in),
        .clear      (clear),
        .capture    (capture),
        .rd_label   (rd_label),
        .rd_stats   (rd_stats),
        .frame_done (frame_done)
    );

    prune_scanner u_scan (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .new_frame_in (new_frame_in),
        .frame_done   (frame_done),
        .rd_stats     (rd_stats),
        .clear        (clear),
        .capture      (capture),
        .rd_label     (rd_label),
        .busy_out     (busy_out),
        .valid_out    (valid_out),
        .num_blobs    (num_blobs),
        .insert       (insert),
        .reset_list   (reset_list),
        .new_blob     (new_blob)
    );

    top_three_tracker u_top3 (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .reset_list (reset_list),
        .insert     (insert),
        .new_blob   (new_blob),
        .top_blobs  (top_blobs)
    );

endmodule

// ==== tests/blob_stats_asserts.sv ====
`timescale 1ns/100ps

module blob_stats_asserts import blob_pkg::*; (
    input logic clk_in,
    input logic rst_in,
    input logic valid_out,
    input logic busy_out,
    input logic div_start,
    input logic x_done,
    input logic y_done
);

    // the result strobe is a single cycle
    assert property (@(posedge clk_in) disable iff (rst_in) valid_out |=> !valid_out)
        else $error("valid_out held high for more than one cycle");

    assert property (@(posedge clk_in) disable iff (rst_in) !(valid_out && busy_out))
        else $error("valid_out and busy_out high in the same cycle");

    // both quotients land a fixed latency after launch
    assert property (@(posedge clk_in) disable iff (rst_in)
        (x_done || y_done) |-> $past(div_start, DIV_CYCLES))
        else $error("divider done without a start DIV_CYCLES earlier");

    assert property (@(posedge clk_in) disable iff (rst_in)
        $past(div_start, DIV_CYCLES) |-> (x_done && y_done))
        else $error("divider start not followed by done after DIV_CYCLES");

endmodule

bind blob_stats_top blob_stats_asserts u_asserts (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .valid_out (valid_out),
    .busy_out  (busy_out),
    .div_start (u_scan.div_start),
    .x_done    (u_scan.x_done),
    .y_done    (u_scan.y_done)
);

// ==== tests/tb_blob_stats.sv ====
`timescale 1ns/100ps

module tb_blob_stats import ccl_frame_pkg::*, blob_pkg::*; ();

    localparam int CLK_PERIOD   = 100;
    localparam int MAX_WORDS    = 128;
    localparam int FRAME_BUDGET = 1300 + 16 * 20;   // cycles allowed per frame

    logic       clk_in = 1'b0;
    logic       rst_in;
    coord_x_t   x_in;
    coord_y_t   y_in;
    label_t     label_in;
    logic       mask_in;
    logic       valid_in;
    logic       new_frame_in;
    logic       valid_out;
    logic       busy_out;
    label_t     num_blobs;
    blob_list_t top_blobs;

    logic [39:0] tdata [MAX_WORDS];             // words from the data file
    label_t      pic [FRAME_HEIGHT][FRAME_WIDTH];   // painted label map of one frame
    blob_list_t  exp_list;
    logic [31:0] lfsr;
    int          rd_ptr;
    int          errors;
    int          passed;
    int          failed;

    always #(CLK_PERIOD / 2) clk_in = ~clk_in;

    blob_stats_top DUT (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .x_in         (x_in),
        .y_in         (y_in),
        .label_in     (label_in),
        .mask_in      (mask_in),
        .valid_in     (valid_in),
        .new_frame_in (new_frame_in),
        .valid_out    (valid_out),
        .busy_out     (busy_out),
        .num_blobs    (num_blobs),
        .top_blobs    (top_blobs)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);   // x^32+x^22+x^2+x+1
    endfunction

    task automatic draw_bit(output logic b);
        b    = lfsr[0];
        lfsr = lfsr_step(lfsr);
    endtask

    function automatic string test_name(input int id);
        case (id)
            1:       return "reset_state";
            2:       return "three_blobs";
            3:       return "prune_threshold";
            4:       return "top_three_ties";
            5:       return "busy_pulse_ignored";
            6:       return "stats_cleared";
            7:       return "valid_gaps";
            default: return "unknown";
        endcase
    endfunction

    function automatic string blob_text(input blob_t b);
        return $sformatf("label %0d area %0d com (%0d,%0d)", b.label, b.area, b.com_x, b.com_y);
    endfunction

    task automatic finish_test(input int id, input int start_errs);
        if (errors == start_errs) begin
            passed++;
            $display("test %0d %s: PASS", id, test_name(id));
        end else begin
            failed++;
            $display("test %0d %s: FAIL with %0d errors", id, test_name(id), errors - start_errs);
        end
    endtask

    // rectangles are inclusive and later ones paint over earlier ones
    task automatic paint_frame(input int nrects);
        logic [39:0] r;
        for (int y = 0; y < FRAME_HEIGHT; y++) begin
            for (int x = 0; x < FRAME_WIDTH; x++) begin
                pic[y][x] = '0;
            end
        end
        for (int n = 0; n < nrects; n++) begin
            r = tdata[rd_ptr];
            rd_ptr++;
            for (int y = int'(r[23:16]); y <= int'(r[7:0]); y++) begin
                for (int x = int'(r[31:24]); x <= int'(r[15:8]); x++) begin
                    pic[y][x] = label_t'(r[39:32]);
                end
            end
        end
    endtask

    // reference model picks the three largest by selection with ties to the lower label
    task automatic build_expected();
        int     area [NUM_LABELS];
        int     xs [NUM_LABELS];
        int     ys [NUM_LABELS];
        logic   taken [NUM_LABELS];
        int     best;
        label_t l;
        for (int i = 0; i < NUM_LABELS; i++) begin
            area[i]  = 0;
            xs[i]    = 0;
            ys[i]    = 0;
            taken[i] = 1'b0;
        end
        for (int y = 0; y < FRAME_HEIGHT; y++) begin
            for (int x = 0; x < FRAME_WIDTH; x++) begin
                l = pic[y][x];
                if (l != '0) begin
                    area[l]++;
                    xs[l] += x;
                    ys[l] += y;
                end
            end
        end
        exp_list = '0;
        for (int k = 0; k < TOP_N; k++) begin
            best = 0;
            for (int i = 1; i < NUM_LABELS; i++) begin
                if (area[i] >= int'(MIN_AREA) && !taken[i] && (best == 0 || area[i] > area[best]))
                    best = i;
            end
            if (best != 0) begin
                taken[best]         = 1'b1;
                exp_list[k].label = label_t'(best);
                exp_list[k].area  = area_t'(area[best]);
                exp_list[k].com_x = coord_x_t'(xs[best] / area[best]);   // floor division
                exp_list[k].com_y = coord_y_t'(ys[best] / area[best]);
            end
        end
    endtask

    task automatic stream_frame(input logic gaps, input logic poke);
        logic b;
        @(negedge clk_in);
        new_frame_in = 1'b1;
        @(negedge clk_in);
        new_frame_in = 1'b0;
        assert (busy_out === 1'b1) else begin
            $display("busy_out did not rise after new_frame_in");
            errors++;
        end
        for (int y = 0; y < FRAME_HEIGHT; y++) begin
            for (int x = 0; x < FRAME_WIDTH; x++) begin
                if (gaps) begin
                    draw_bit(b);
                    if (b) begin
                        valid_in = 1'b0;        // idle cycle before this pixel
                        @(negedge clk_in);
                    end
                end
                x_in         = coord_x_t'(x);
                y_in         = coord_y_t'(y);
                label_in     = pic[y][x];
                mask_in      = (pic[y][x] != '0);
                valid_in     = 1'b1;
                new_frame_in = poke && (y == 10) && (x == 0);   // mid-capture request
                @(negedge clk_in);
            end
        end
        valid_in     = 1'b0;
        mask_in      = 1'b0;
        @(negedge clk_in);
        new_frame_in = poke;                    // second request once the scan has begun
        @(negedge clk_in);
        new_frame_in = 1'b0;
    endtask

    task automatic check_outputs(input string name, input int file_count);
        assert (busy_out === 1'b0) else begin
            $display("%s: busy_out still high in the valid_out cycle", name);
            errors++;
        end
        assert (num_blobs == label_t'(file_count)) else begin
            $display("mismatch %s num_blobs expected %0d actual %0d", name, file_count, num_blobs);
            errors++;
        end
        for (int k = 0; k < TOP_N; k++) begin
            assert (top_blobs[k] == exp_list[k]) else begin
                $display("mismatch %s top_blobs[%0d] expected %s actual %s", name, k,
                         blob_text(exp_list[k]), blob_text(top_blobs[k]));
                errors++;
            end
        end
    endtask

    task automatic run_frame();
        logic [39:0] hdr;
        int          id;
        int          start_errs;
        hdr = tdata[rd_ptr];
        rd_ptr++;
        id         = int'(hdr[39:32]);
        start_errs = errors;
        paint_frame(int'(hdr[31:24]));
        build_expected();
        stream_frame(hdr[8], hdr[0]);
        while (valid_out !== 1'b1) begin
            @(negedge clk_in);
        end
        check_outputs(test_name(id), int'(hdr[23:16]));
        finish_test(id, start_errs);
    endtask

    initial begin
        int start_errs;
        rst_in       = 1'b1;
        x_in         = '0;
        y_in         = '0;
        label_in     = '0;
        mask_in      = 1'b0;
        valid_in     = 1'b0;
        new_frame_in = 1'b0;
        errors       = 0;
        passed       = 0;
        failed       = 0;
        lfsr         = 32'h0349_776e;
        $readmemh("tests/blob_testdata.txt", tdata);
        rd_ptr = 1;
        repeat (2) @(posedge clk_in);
        @(negedge clk_in);
        rst_in = 1'b0;
        @(negedge clk_in);

        start_errs = errors;
        assert (busy_out === 1'b0 && valid_out === 1'b0) else begin
            $display("busy_out or valid_out not low after reset");
            errors++;
        end
        assert (top_blobs === '0 && num_blobs === '0) else begin
            $display("mismatch reset_state outputs expected 0 actual %h / %0d", top_blobs,
                     num_blobs);
            errors++;
        end
        finish_test(1, start_errs);

        for (int f = 0; f < int'(tdata[0]); f++) begin
            run_frame();
        end

        $display("tests run %0d, passed %0d, failed %0d, failed checks %0d",
                 passed + failed, passed, failed, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // watchdog sized from the frame count in the data file
    initial begin
        int limit;
        #1;
        limit = int'(tdata[0]) * FRAME_BUDGET + 20;
        repeat (limit) @(posedge clk_in);
        $display("timeout: no final result within %0d clock cycles", limit);
        $display("Test failed");
        $finish;
    end

endmodule

// ==== tests/blob_testdata.txt ====
// header: test id, rectangle count, expected num_blobs, valid gaps flag, busy pulse flag
// rectangle: label, x0, y0, x1, y1 (inclusive, all hex); first word is the frame count
00_00_00_00_06
// three separate blobs
02_03_03_00_00
01_02_02_0b_09
02_14_03_22_0c
03_05_0f_0e_1a
// 49 next to 50, small ones, one blob split by overwrite
03_07_04_00_00
04_01_01_07_07
05_08_01_0c_0a
06_1e_14_20_16
07_19_05_26_0e
09_00_1c_27_1c
08_0f_0f_18_18
0a_0f_0f_13_18
// five retained, tie of area 100 between labels 3 and 11
04_05_05_00_00
03_00_00_09_09
06_0c_00_17_09
0b_1a_00_23_09
0d_00_0e_07_16
0f_0c_0e_14_16
// full frame blob with a hole and a masked last pixel, new_frame_in while busy
05_03_02_00_01
07_00_00_27_1d
02_0a_0a_13_13
0f_27_1d_27_1d
// labels of the last frame are absent here
06_01_01_00_00
01_1e_14_27_1d
// same as the three blob frame, with valid gaps
07_03_03_01_00
01_02_02_0b_09
02_14_03_22_0c
03_05_0f_0e_1a

// ==== project.f ====
hw/ccl_frame_pkg.sv
hw/blob_pkg.sv
hw/label_accumulator.sv
hw/serial_divider.sv
hw/prune_scanner.sv
hw/top_three_tracker.sv
hw/blob_stats_top.sv
tests/blob_stats_asserts.sv
tests/tb_blob_stats.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, then search the log for the fail message
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_blob_stats \
    -Mdir obj_dir -o sim_blob_stats -f project.f \
    || { echo "verilator build failed"; exit 1; }
./obj_dir/sim_blob_stats > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log
grep -q "Test failed" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "Test completed successfully" sim.log || { echo "run did not complete"; exit 1; }
exit 0
